// File: Bender.yml
package:
  name: dual_issue_core

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/core_pkg.sv
      - rtl/fetch_stage.sv
      - rtl/inst_decode.sv
      - rtl/alu_execute.sv
      - rtl/result_stage.sv
      - rtl/dual_issue_core.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/core_tb.sv

// File: build.f
+incdir+rtl
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/inst_decode.sv
rtl/alu_execute.sv
rtl/result_stage.sv
rtl/dual_issue_core.sv
sim/core_tb.sv

// File: rtl/alu_execute.sv
`timescale 1ns/1ps

`include "core_settings.svh"

module alu_execute (
	input  core_pkg::issue_bundle_t          issue,
	output core_pkg::reg_addr_t [3:0]        read_addr,   // ra0, rb0, ra1, rb1
	input  logic [3:0][`CORE_XLEN-1:0]       read_data,
	output core_pkg::exec_result_t [1:0]     result
);

	import core_pkg::*;

	logic [1:0][`CORE_XLEN-1:0] op_a;
	logic [1:0][`CORE_XLEN-1:0] op_b;
	logic [1:0][`CORE_XLEN-1:0] imm_ext;   // sign extended immediate
	logic [1:0][`CORE_XLEN-1:0] alu_out;

	////////////////////////////////////////
	// register file reads
	////////////////////////////////////////

	assign read_addr[0] = issue[0].ra;
	assign read_addr[1] = issue[0].rb;
	assign read_addr[2] = issue[1].ra;
	assign read_addr[3] = issue[1].rb;

	////////////////////////////////////////
	// one alu per slot
	////////////////////////////////////////

	always_comb
	begin
		for (int s = 0; s < 2; s++)
		begin
			imm_ext[s] = {{(`CORE_XLEN-16){issue[s].imm[15]}}, issue[s].imm};
			op_a[s]    = read_data[2*s];
			op_b[s]    = issue[s].use_imm ? imm_ext[s] : read_data[2*s+1];   // addi takes imm

			case (issue[s].alu_op)
				alu_add: alu_out[s] = op_a[s] + op_b[s];
				alu_sub: alu_out[s] = op_a[s] - op_b[s];
				alu_and: alu_out[s] = op_a[s] & op_b[s];
				alu_or:  alu_out[s] = op_a[s] | op_b[s];
				alu_xor: alu_out[s] = op_a[s] ^ op_b[s];
				alu_lui: alu_out[s] = imm_ext[s] << 16;   // upper immediate, still sign extended
				default: alu_out[s] = '0;                 // nop
			endcase

			// nops consume the slot but produce nothing
			result[s].valid = issue[s].valid && (issue[s].alu_op != alu_nop);
			result[s].pc    = issue[s].pc;
			result[s].rd    = issue[s].rd;
			result[s].value = alu_out[s];
		end
	end

endmodule

// File: rtl/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

	////////////////////////////////////////
	// instruction set
	////////////////////////////////////////

	// register index, 5 bits for 32 registers
	typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_addr_t;

	// opcode field is word[31:26]
	// rd word[25:21], ra word[20:16], rb word[15:11], imm word[15:0]
	// rb overlaps the top of imm, only register forms read it
	typedef enum logic [5:0] {
		op_nop  = 6'd0,
		op_add  = 6'd1,
		op_sub  = 6'd2,
		op_and  = 6'd3,
		op_or   = 6'd4,
		op_xor  = 6'd5,
		op_addi = 6'd6,
		op_lui  = 6'd7
	} opcode_e;

	// alu function, alu_nop marks a slot that produces nothing
	typedef enum logic [2:0] {
		alu_nop,
		alu_add,    // also used by addi with use_imm set
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_lui
	} alu_op_e;

	////////////////////////////////////////
	// stage bundles
	////////////////////////////////////////

	typedef struct packed {
		logic                  valid;
		logic [`CORE_XLEN-1:0] pc;
		logic [31:0]           word;   // raw instruction
	} fetch_slot_t;

	typedef fetch_slot_t [1:0] fetch_bundle_t;   // [0] is the older slot

	typedef struct packed {
		logic                  valid;
		logic [`CORE_XLEN-1:0] pc;
		alu_op_e               alu_op;
		reg_addr_t             rd;
		reg_addr_t             ra;
		reg_addr_t             rb;
		logic                  use_imm;   // operand b is the sign extended imm
		logic [15:0]           imm;
	} issue_slot_t;

	typedef issue_slot_t [1:0] issue_bundle_t;

	typedef struct packed {
		logic                  valid;
		logic [`CORE_XLEN-1:0] pc;
		reg_addr_t             rd;
		logic [`CORE_XLEN-1:0] value;
	} exec_result_t;

	// registered architectural view of a finished instruction
	typedef struct packed {
		logic                  valid;
		logic [`CORE_XLEN-1:0] pc;
		reg_addr_t             rd;
		logic [`CORE_XLEN-1:0] value;
	} retire_t;

endpackage

// File: rtl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

////////////////////////////////////////
// architectural constants of the core
////////////////////////////////////////

// data path and address width
`define CORE_XLEN 64

// architectural registers, zero register included
`define CORE_REG_COUNT 32

// index that always reads zero, writes to it are dropped
`define CORE_ZERO_REG 31

// first fetch address out of reset
`define CORE_RESET_PC 64'h0

`endif

// File: rtl/dual_issue_core.sv
`timescale 1ns/1ps

`include "core_settings.svh"

module dual_issue_core (
	input  logic                  clock,
	input  logic                  reset,
	output logic [`CORE_XLEN-1:0] imem_addr,
	input  logic [`CORE_XLEN-1:0] imem_data,
	input  logic                  imem_valid,
	output core_pkg::retire_t     retire0,
	output core_pkg::retire_t     retire1
);

	import core_pkg::*;

	fetch_bundle_t              fetch;         // fetch -> decode
	logic [1:0]                 issue_count;   // decode -> fetch
	issue_bundle_t              issue;         // decode -> execute
	reg_addr_t [3:0]            read_addr;     // execute -> register file
	logic [3:0][`CORE_XLEN-1:0] read_data;
	exec_result_t [1:0]         result;        // execute -> result

	fetch_stage i_fetch (
		.clock       (clock),
		.reset       (reset),
		.issue_count (issue_count),
		.imem_data   (imem_data),
		.imem_valid  (imem_valid),
		.imem_addr   (imem_addr),
		.fetch       (fetch)
	);

	inst_decode i_decode (
		.clock       (clock),
		.reset       (reset),
		.fetch       (fetch),
		.issue_count (issue_count),
		.issue       (issue)
	);

	alu_execute i_execute (
		.issue     (issue),
		.read_addr (read_addr),
		.read_data (read_data),
		.result    (result)
	);

	result_stage i_result (
		.clock     (clock),
		.reset     (reset),
		.read_addr (read_addr),
		.read_data (read_data),
		.result    (result),
		.retire0   (retire0),
		.retire1   (retire1)
	);

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps

`include "core_settings.svh"

module fetch_stage (
	input  logic                    clock,
	input  logic                    reset,
	input  logic [1:0]              issue_count,   // slots taken by decode this cycle
	input  logic [`CORE_XLEN-1:0]   imem_data,     // two 32-bit slots
	input  logic                    imem_valid,
	output logic [`CORE_XLEN-1:0]   imem_addr,
	output core_pkg::fetch_bundle_t fetch
);

	logic [`CORE_XLEN-1:0] pc;        // address of the oldest unissued instruction
	logic [`CORE_XLEN-1:0] next_pc;
	logic [`CORE_XLEN-1:0] pc_step;   // 0, 4 or 8 bytes

	////////////////////////////////////////
	// memory address and slot extraction
	////////////////////////////////////////

	// memory returns one aligned doubleword
	assign imem_addr = {pc[`CORE_XLEN-1:3], 3'b000};

	// slot0 starts wherever the pc points inside the doubleword
	assign fetch[0].valid = imem_valid;
	assign fetch[0].pc    = pc;
	assign fetch[0].word  = pc[2] ? imem_data[63:32] : imem_data[31:0];

	// second slot only exists when pc sits in the low half
	assign fetch[1].valid = imem_valid & ~pc[2];
	assign fetch[1].pc    = pc + `CORE_XLEN'(4);
	assign fetch[1].word  = imem_data[63:32];

	////////////////////////////////////////
	// pc update
	////////////////////////////////////////

	assign pc_step = {{(`CORE_XLEN-4){1'b0}}, issue_count, 2'b00};   // four bytes per slot
	assign next_pc = pc + pc_step;   // count of 0 holds the pc

	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= `CORE_RESET_PC;
		else
			pc <= next_pc;
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// pc only ever moves by whole instructions
	pc_aligned: assert property (@(posedge clock) disable iff (reset)
		pc[1:0] == 2'b00)
		else $error("fetch_stage: misaligned pc %h", pc);

	// decode never takes more than fetch offered
	count_in_range: assert property (@(posedge clock) disable iff (reset)
		issue_count <= {1'b0, fetch[0].valid} + {1'b0, fetch[1].valid})
		else $error("fetch_stage: issue_count %0d beyond valid slots", issue_count);

endmodule

// File: rtl/inst_decode.sv
`timescale 1ns/1ps

`include "core_settings.svh"

module inst_decode (
	input  logic                    clock,
	input  logic                    reset,
	input  core_pkg::fetch_bundle_t fetch,
	output logic [1:0]              issue_count,   // back to fetch, same cycle
	output core_pkg::issue_bundle_t issue
);

	import core_pkg::*;

	localparam reg_addr_t zero_reg = reg_addr_t'(`CORE_ZERO_REG);

	issue_bundle_t decoded;      // both slots decoded, before the issue decision
	issue_bundle_t issue_next;
	logic          raw_hazard;   // slot1 reads what slot0 writes
	logic          waw_hazard;   // both slots write the same register

	// opcode to alu function and operand selection
	function automatic issue_slot_t decode_slot(input fetch_slot_t slot);
		issue_slot_t d;
		opcode_e     op;

		op        = opcode_e'(slot.word[31:26]);
		d.valid   = slot.valid;
		d.pc      = slot.pc;
		d.rd      = slot.word[25:21];
		d.ra      = slot.word[20:16];
		d.rb      = slot.word[15:11];
		d.imm     = slot.word[15:0];
		d.use_imm = 1'b0;
		d.alu_op  = alu_nop;
		case (op)
			op_add: d.alu_op = alu_add;
			op_sub: d.alu_op = alu_sub;
			op_and: d.alu_op = alu_and;
			op_or:  d.alu_op = alu_or;
			op_xor: d.alu_op = alu_xor;
			op_addi:
			begin
				d.alu_op  = alu_add;
				d.use_imm = 1'b1;
			end
			op_lui:
			begin
				d.alu_op  = alu_lui;
				d.use_imm = 1'b1;
				d.ra      = zero_reg;   // no register source
			end
			default:
			begin
				// nop and undefined opcodes touch no register
				d.rd = zero_reg;
				d.ra = zero_reg;
				d.rb = zero_reg;
			end
		endcase
		return d;
	endfunction

	assign decoded[0] = decode_slot(fetch[0]);
	assign decoded[1] = decode_slot(fetch[1]);

	////////////////////////////////////////
	// issue decision
	////////////////////////////////////////

	// rb only matters for the register forms
	assign raw_hazard = (decoded[0].rd != zero_reg)
		&& ((decoded[1].ra == decoded[0].rd)
		|| (!decoded[1].use_imm && (decoded[1].rb == decoded[0].rd)));

	assign waw_hazard = (decoded[0].rd != zero_reg) && (decoded[1].rd == decoded[0].rd);

	always_comb
	begin
		if (!decoded[0].valid)
			issue_count = 2'd0;   // memory stall
		else if (!decoded[1].valid || raw_hazard || waw_hazard)
			issue_count = 2'd1;   // slot1 waits for the next cycle
		else
			issue_count = 2'd2;
	end

	always_comb
	begin
		issue_next          = decoded;
		issue_next[0].valid = (issue_count != 2'd0);
		issue_next[1].valid = (issue_count == 2'd2);   // held slot goes down as a bubble
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			issue[0].valid <= 1'b0;
			issue[1].valid <= 1'b0;
		end
		else
			issue <= issue_next;
	end

	// younger slot never issues without the older one
	slot_order: assert property (@(posedge clock) disable iff (reset)
		issue[1].valid |-> issue[0].valid)
		else $error("inst_decode: slot1 issued without slot0");

endmodule

// File: rtl/result_stage.sv
`timescale 1ns/1ps

`include "core_settings.svh"

module result_stage (
	input  logic                            clock,
	input  logic                            reset,
	input  core_pkg::reg_addr_t [3:0]       read_addr,
	output logic [3:0][`CORE_XLEN-1:0]      read_data,
	input  core_pkg::exec_result_t [1:0]    result,
	output core_pkg::retire_t               retire0,
	output core_pkg::retire_t               retire1
);

	import core_pkg::*;

	localparam reg_addr_t zero_reg = reg_addr_t'(`CORE_ZERO_REG);

	// writable registers 0..30, the zero register has no storage
	logic [`CORE_XLEN-1:0] regs [0:`CORE_REG_COUNT-2];

	////////////////////////////////////////
	// register file
	////////////////////////////////////////

	always_comb
	begin
		for (int p = 0; p < 4; p++)
			read_data[p] = (read_addr[p] == zero_reg) ? '0 : regs[read_addr[p]];
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int r = 0; r < `CORE_REG_COUNT-1; r++)
				regs[r] <= '0;
		end
		else
		begin
			// slot1 after slot0, decode keeps their rd apart
			for (int s = 0; s < 2; s++)
				if (result[s].valid && (result[s].rd != zero_reg))
					regs[result[s].rd] <= result[s].value;
		end
	end

	////////////////////////////////////////
	// retire ports
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			retire0.valid <= 1'b0;
			retire1.valid <= 1'b0;
		end
		else if (result[0].valid)
		begin
			// rd 31 results still retire with their value
			retire0 <= '{valid: result[0].valid, pc: result[0].pc,
				rd: result[0].rd, value: result[0].value};
			retire1 <= '{valid: result[1].valid, pc: result[1].pc,
				rd: result[1].rd, value: result[1].value};
		end
		else
		begin
			// older slot was a nop, younger result moves down to retire0
			retire0 <= '{valid: result[1].valid, pc: result[1].pc,
				rd: result[1].rd, value: result[1].value};
			retire1.valid <= 1'b0;
		end
	end

	// decode must have split any same-rd pair
	no_double_write: assert property (@(posedge clock) disable iff (reset)
		!(result[0].valid && result[1].valid
		&& (result[0].rd == result[1].rd) && (result[0].rd != zero_reg)))
		else $error("result_stage: both slots write r%0d", result[0].rd);

endmodule

// File: sim/core_tb.sv
`timescale 1ns/1ps

`include "core_settings.svh"

module core_tb;

	import core_pkg::*;

	localparam int program_words  = 256;
	localparam int timeout_cycles = 4*program_words + 40;   // worst case stall mix plus slack

	logic                  clock;
	logic                  reset;
	logic [`CORE_XLEN-1:0] imem_addr;
	logic [`CORE_XLEN-1:0] imem_data;
	logic                  imem_valid;
	retire_t               retire0;
	retire_t               retire1;

	logic [31:0]           lcg_state;
	logic [31:0]           program_mem [0:program_words-1];
	logic [`CORE_XLEN-1:0] model_regs [0:`CORE_REG_COUNT-1];
	logic [`CORE_XLEN-1:0] word_index;        // imem_addr in 32-bit words
	retire_t               expected_q [$];    // model output, program order
	int                    expected_total;
	int                    retired_count;
	int                    cycle_count;
	int                    cycles_after_reset;
	logic [1:0]            stall_hist;        // [1] is imem_valid low two cycles back

	dual_issue_core i_dut (
		.clock      (clock),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.imem_valid (imem_valid),
		.retire0    (retire0),
		.retire1    (retire1)
	);

	always #20 clock = ~clock;   // 40 ns period

	////////////////////////////////////////
	// random source and program
	////////////////////////////////////////

	function automatic logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];   // low lcg bits are poor
	endfunction

	// mostly r0, r1, r2 or r31 so hazards and the zero register show up often
	function automatic logic [4:0] pick_reg();
		logic [15:0] r;
		r = next_random();
		if (r[3:0] < 4'd12)
			return (r[5:4] == 2'd3) ? 5'd31 : {3'b000, r[5:4]};
		return r[12:8];
	endfunction

	function automatic logic [5:0] pick_opcode();
		logic [15:0] r;
		r = next_random();
		if (r[3:0] == 4'd0)
			return 6'd0;                            // nop
		if (r[3:0] == 4'd1)
			return 6'd8 + 6'(r[9:4] % 56);          // undefined, 8..63
		return 6'd1 + 6'((r[3:0] - 4'd2) % 7);      // add .. lui
	endfunction

	// beyond the program every word is a nop, low bits folded from the full index
	function automatic logic [31:0] fill_word(input logic [`CORE_XLEN-1:0] index);
		return {6'd0, 26'(index ^ (index >> 26) ^ (index >> 52))};
	endfunction

	task automatic build_program();
		logic [5:0]  op;
		logic [4:0]  rd;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [15:0] low;
		logic [15:0] imm;   // top five bits double as rb
		for (int i = 0; i < program_words; i++)
		begin
			op  = pick_opcode();
			rd  = pick_reg();
			ra  = pick_reg();
			rb  = pick_reg();
			low = next_random();
			imm = {rb, low[10:0]};
			program_mem[i] = {op, rd, ra, imm};
		end
	endtask

	// combinational memory, one aligned doubleword per address
	always_comb
	begin
		word_index = imem_addr >> 2;
		for (int h = 0; h < 2; h++)
			if (word_index + h < program_words)
				imem_data[32*h +: 32] = program_mem[word_index + h];
			else
				imem_data[32*h +: 32] = fill_word(word_index + h);
	end

	always @(posedge clock)
		imem_valid <= (next_random() % 4 != 0);   // low about one cycle in four

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	function automatic logic [`CORE_XLEN-1:0] read_model_reg(input logic [4:0] index);
		return (index == `CORE_ZERO_REG) ? '0 : model_regs[index];
	endfunction

	task automatic run_model();
		logic [31:0]           w;
		logic [4:0]            rd;
		logic [`CORE_XLEN-1:0] a;
		logic [`CORE_XLEN-1:0] b;
		logic [`CORE_XLEN-1:0] imm_ext;
		logic [`CORE_XLEN-1:0] value;
		logic                  has_result;
		for (int r = 0; r < `CORE_REG_COUNT; r++)
			model_regs[r] = '0;   // matches the register file after reset
		for (int i = 0; i < program_words; i++)
		begin
			w          = program_mem[i];
			rd         = w[25:21];
			a          = read_model_reg(w[20:16]);
			b          = read_model_reg(w[15:11]);
			imm_ext    = {{(`CORE_XLEN-16){w[15]}}, w[15:0]};
			has_result = 1'b1;
			case (opcode_e'(w[31:26]))
				op_add:  value = a + b;
				op_sub:  value = a - b;
				op_and:  value = a & b;
				op_or:   value = a | b;
				op_xor:  value = a ^ b;
				op_addi: value = a + imm_ext;
				op_lui:  value = imm_ext << 16;
				default: has_result = 1'b0;   // nop and undefined never retire
			endcase
			if (has_result)
			begin
				expected_q.push_back('{valid: 1'b1, pc: `CORE_XLEN'(i*4), rd: rd, value: value});
				if (rd != `CORE_ZERO_REG)
					model_regs[rd] = value;
			end
		end
	endtask

	// slot1 may not read or rewrite what slot0 writes, zero register aside
	function automatic logic pair_conflicts(input retire_t older, input retire_t younger);
		logic [31:0] w;
		opcode_e     op;
		logic        reads_ra;
		logic        reads_rb;
		w        = program_mem[younger.pc >> 2];
		op       = opcode_e'(w[31:26]);
		reads_rb = (op == op_add) || (op == op_sub) || (op == op_and)
			|| (op == op_or) || (op == op_xor);
		reads_ra = reads_rb || (op == op_addi);   // lui has no register source
		if (older.rd == `CORE_ZERO_REG)
			return 1'b0;
		return (younger.rd == older.rd)
			|| (reads_ra && (w[20:16] == older.rd))
			|| (reads_rb && (w[15:11] == older.rd));
	endfunction

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_retire(input string name, input retire_t expected, input retire_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected pc=%h rd=%0d value=%h actual pc=%h rd=%0d value=%h",
				name, expected.pc, expected.rd, expected.value,
				actual.pc, actual.rd, actual.value);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input logic [`CORE_XLEN-1:0] expected,
		input logic [`CORE_XLEN-1:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic take_retire(input retire_t actual, input string port);
		retire_t expected;
		if (expected_q.size() == 0)
		begin
			$display("%s retired pc %h after the whole program had retired", port, actual.pc);
			abort_run();
		end
		else
		begin
			expected = expected_q.pop_front();
			check_retire($sformatf("%s instruction %0d", port, retired_count), expected, actual);
			retired_count++;
		end
	endtask

	////////////////////////////////////////
	// retire monitor, sampled mid cycle
	////////////////////////////////////////

	always @(negedge clock)
	begin
		if (reset)
		begin
			stall_hist         = 2'b00;
			cycles_after_reset = 0;
		end
		else
		begin
			// pipeline empty for two cycles, and a stalled fetch retires nothing later
			if ((cycles_after_reset < 2 || stall_hist[1]) && (retire0.valid || retire1.valid))
			begin
				$display("retire in cycle %0d with nothing fetched two cycles before", cycle_count);
				abort_run();
			end
			if (retire1.valid && !retire0.valid)
			begin
				$display("retire1 valid without retire0 in cycle %0d", cycle_count);
				abort_run();
			end
			if (retire0.valid)
				take_retire(retire0, "retire0");
			if (retire1.valid)
				take_retire(retire1, "retire1");   // younger of the pair
			if (retire0.valid && retire1.valid && pair_conflicts(retire0, retire1))
			begin
				$display("dependent pair at pc %h retired in one cycle", retire0.pc);
				abort_run();
			end
			stall_hist = {stall_hist[0], !imem_valid};
			cycles_after_reset++;
		end
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count > timeout_cycles)
		begin
			$display("timeout after %0d cycles, %0d of %0d instructions retired",
				cycle_count, retired_count, expected_total);
			abort_run();
		end
	end

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		clock              = 1'b0;
		reset              = 1'b1;
		imem_valid         = 1'b0;
		lcg_state          = 32'd24;   // seed
		retired_count      = 0;
		cycle_count        = 0;
		cycles_after_reset = 0;
		stall_hist         = 2'b00;
		build_program();
		run_model();
		expected_total = expected_q.size();

		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_addr("first fetch address", `CORE_RESET_PC, imem_addr);

		// fetch has moved past the last program word
		wait (imem_addr >= 4*program_words);
		repeat (4) @(negedge clock);   // two cycles to retire, trailing nops stay quiet
		check_count("retired instructions", expected_total, retired_count);
		$display("Everything OK");
		$finish;
	end

endmodule
